// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - hw/mem_stage_pkg.sv
      - hw/operand_decode.sv
      - hw/rep_addr_unit.sv
      - hw/data_mem.sv
      - hw/operand_mux.sv
      - hw/stage_result_reg.sv
      - hw/mem_stage_top.sv
  - target: test
    files:
      - test/tb_mem_stage.sv

// File: hw/data_mem.sv
module data_mem import mem_stage_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [ADDR_W-1:0] raddr1_i,
    input  logic [ADDR_W-1:0] raddr2_i,
    input  op_size_e          rsize_i,
    input  logic              wb_valid_i,
    input  logic [ADDR_W-1:0] wb_addr_i,
    input  logic [DATA_W-1:0] wb_data_i,
    input  op_size_e          wb_size_i,
    output logic [DATA_W-1:0] rdata1_o,
    output logic [DATA_W-1:0] rdata2_o
);

    logic [BYTE_LANES-1:0][7:0] mem_q [MEM_WORDS];
    logic [IDX_W-1:0]           wb_word;
    logic [OFF_W-1:0]           wb_off;
    logic [3:0]                 wb_nbytes;

    // rotate right by the byte offset, keep only the bytes of the access size
    function automatic logic [DATA_W-1:0] read_lanes(
        input logic [BYTE_LANES-1:0][7:0] word,
        input logic [OFF_W-1:0]           off,
        input op_size_e                   size
    );
        logic [DATA_W-1:0] rot;
        logic [OFF_W-1:0]  lane;
        logic [3:0]        nbytes;
        nbytes = 4'(1) << size;
        for (int b = 0; b < BYTE_LANES; b++) begin
            lane = off + OFF_W'(b);
            rot[b*8 +: 8] = (b < nbytes) ? word[lane] : 8'h00;
        end
        return rot;
    endfunction

    assign rdata1_o = read_lanes(mem_q[raddr1_i[OFF_W +: IDX_W]], raddr1_i[OFF_W-1:0], rsize_i);
    assign rdata2_o = read_lanes(mem_q[raddr2_i[OFF_W +: IDX_W]], raddr2_i[OFF_W-1:0], rsize_i);

    assign wb_word   = wb_addr_i[OFF_W +: IDX_W];
    assign wb_off    = wb_addr_i[OFF_W-1:0];
    assign wb_nbytes = 4'(1) << wb_size_i;

    // bytes past the end of the word wrap back to lane 0
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (wb_valid_i) begin
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (b < wb_nbytes) begin
                    mem_q[wb_word][wb_off + OFF_W'(b)] <= wb_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: hw/mem_stage_pkg.sv
package mem_stage_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int SEG_W      = 16;
    localparam int NUM_OPS    = 4;
    localparam int MEM_WORDS  = 256;
    localparam int BYTE_LANES = DATA_W / 8;
    // byte offset inside a word, then word index
    localparam int OFF_W      = 3;
    localparam int IDX_W      = 8;

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_REG,
        SRC_SEG,
        SRC_MEM1,
        SRC_MEM2,
        SRC_IMM,
        SRC_EIP
    } op_src_e;

    typedef enum logic [2:0] {
        DEST_NONE,
        DEST_REG,
        DEST_SEG,
        DEST_MEM1,
        DEST_MEM2
    } dest_kind_e;

    // 1, 2, 4 and 8 bytes
    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_WORD,
        SZ_DWORD,
        SZ_QWORD
    } op_size_e;

    typedef enum logic {
        REP_IDLE,
        REP_RUN
    } rep_state_e;

    typedef struct packed {
        op_src_e    src;
        logic [1:0] idx;
    } op_sel_t;

    typedef struct packed {
        dest_kind_e kind;
        logic [1:0] idx;
    } dest_sel_t;

    typedef struct packed {
        logic [31:0] eip;
        logic [6:0]  tag;
        logic [4:0]  aluk;
        logic        is_br;
        logic        is_fp;
        logic        is_imm;
        logic        is_rep;
    } pipe_ctrl_t;

    typedef struct packed {
        logic rd1;
        logic wr1;
        logic rd2;
        logic wr2;
    } mem_use_t;

    typedef struct packed {
        logic [NUM_OPS-1:0][DATA_W-1:0] op_val;
        logic [NUM_OPS-1:0][ADDR_W-1:0] dest_addr;
        dest_kind_e [NUM_OPS-1:0]       dest_kind;
        op_size_e                       size;
        pipe_ctrl_t                     ctrl;
    } stage_out_t;

endpackage

// File: hw/mem_stage_top.sv
module mem_stage_top import mem_stage_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             valid_i,
    input  op_sel_t    [NUM_OPS-1:0]         op_sel_i,
    input  dest_sel_t  [NUM_OPS-1:0]         dest_sel_i,
    input  op_size_e                         size_i,
    input  logic                             df_i,
    input  logic                             is_rep_i,
    input  logic       [ADDR_W-1:0]          mem_addr1_i,
    input  logic       [ADDR_W-1:0]          mem_addr2_i,
    input  logic       [ADDR_W-1:0]          count_i,
    input  logic       [NUM_OPS-1:0][DATA_W-1:0] regs_i,
    input  logic       [NUM_OPS-1:0][SEG_W-1:0]  segs_i,
    input  logic       [DATA_W-1:0]          imm_i,
    input  pipe_ctrl_t                       ctrl_i,
    input  logic                             fwd_stall_i,
    input  logic                             wb_valid_i,
    input  logic       [ADDR_W-1:0]          wb_addr_i,
    input  logic       [DATA_W-1:0]          wb_data_i,
    input  op_size_e                         wb_size_i,
    output logic                             valid_o,
    output stage_out_t                       out_o,
    output logic                             stall_o
);

    op_sel_t    [NUM_OPS-1:0]             dec_src;
    dest_kind_e [NUM_OPS-1:0]             dest_kind;
    mem_use_t                             mem_use;
    logic       [ADDR_W-1:0]              cur_addr1;
    logic       [ADDR_W-1:0]              cur_addr2;
    logic                                 rep_fire;
    logic                                 rep_stall;
    logic                                 hold;
    logic       [DATA_W-1:0]              rdata1;
    logic       [DATA_W-1:0]              rdata2;
    logic       [NUM_OPS-1:0][DATA_W-1:0] op_val;
    logic       [NUM_OPS-1:0][ADDR_W-1:0] dest_addr;
    stage_out_t                           next_out;

    // decode
    operand_decode u_decode (
        .op_sel_i    (op_sel_i),
        .dest_sel_i  (dest_sel_i),
        .dec_src_o   (dec_src),
        .dest_kind_o (dest_kind),
        .mem_use_o   (mem_use)
    );

    // execute
    rep_addr_unit u_rep (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .is_rep_i     (is_rep_i),
        .df_i         (df_i),
        .size_i       (size_i),
        .mem_addr1_i  (mem_addr1_i),
        .mem_addr2_i  (mem_addr2_i),
        .count_i      (count_i),
        .hold_i       (hold),
        .cur_addr1_o  (cur_addr1),
        .cur_addr2_o  (cur_addr2),
        .item_valid_o (rep_fire),
        .rep_stall_o  (rep_stall)
    );

    data_mem u_mem (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .raddr1_i   (cur_addr1),
        .raddr2_i   (cur_addr2),
        .rsize_i    (size_i),
        .wb_valid_i (wb_valid_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .wb_size_i  (wb_size_i),
        .rdata1_o   (rdata1),
        .rdata2_o   (rdata2)
    );

    operand_mux u_mux (
        .dec_src_i   (dec_src),
        .mem_use_i   (mem_use),
        .dest_sel_i  (dest_sel_i),
        .regs_i      (regs_i),
        .segs_i      (segs_i),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .addr1_i     (cur_addr1),
        .addr2_i     (cur_addr2),
        .imm_i       (imm_i),
        .eip_i       (ctrl_i.eip),
        .op_val_o    (op_val),
        .dest_addr_o (dest_addr)
    );

    assign next_out.op_val    = op_val;
    assign next_out.dest_addr = dest_addr;
    assign next_out.dest_kind = dest_kind;
    assign next_out.size      = size_i;
    assign next_out.ctrl      = ctrl_i;

    // result
    stage_result_reg u_result (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .item_valid_i (rep_fire),
        .fwd_stall_i  (fwd_stall_i),
        .rep_stall_i  (rep_stall),
        .next_i       (next_out),
        .valid_o      (valid_o),
        .out_o        (out_o),
        .stall_o      (stall_o),
        .hold_o       (hold)
    );

endmodule

// File: hw/operand_decode.sv
module operand_decode import mem_stage_pkg::*; (
    input  op_sel_t    [NUM_OPS-1:0] op_sel_i,
    input  dest_sel_t  [NUM_OPS-1:0] dest_sel_i,
    output op_sel_t    [NUM_OPS-1:0] dec_src_o,
    output dest_kind_e [NUM_OPS-1:0] dest_kind_o,
    output mem_use_t                 mem_use_o
);

    // unused or unknown operand encodings collapse to none
    always_comb begin
        for (int i = 0; i < NUM_OPS; i++) begin
            if (op_sel_i[i].src == SRC_NONE || op_sel_i[i].src > SRC_EIP) begin
                dec_src_o[i].src = SRC_NONE;
                dec_src_o[i].idx = 2'd0;
            end else begin
                dec_src_o[i] = op_sel_i[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_OPS; i++) begin
            if (dest_sel_i[i].kind > DEST_MEM2) begin
                dest_kind_o[i] = DEST_NONE;
            end else begin
                dest_kind_o[i] = dest_sel_i[i].kind;
            end
        end
    end

    // a memory port is read if any operand names it, written if any destination does
    always_comb begin
        mem_use_o = '0;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (op_sel_i[i].src == SRC_MEM1) begin
                mem_use_o.rd1 = 1'b1;
            end
            if (op_sel_i[i].src == SRC_MEM2) begin
                mem_use_o.rd2 = 1'b1;
            end
            if (dest_sel_i[i].kind == DEST_MEM1) begin
                mem_use_o.wr1 = 1'b1;
            end
            if (dest_sel_i[i].kind == DEST_MEM2) begin
                mem_use_o.wr2 = 1'b1;
            end
        end
    end

endmodule

// File: hw/operand_mux.sv
module operand_mux import mem_stage_pkg::*; (
    input  op_sel_t   [NUM_OPS-1:0]             dec_src_i,
    input  mem_use_t                            mem_use_i,
    input  dest_sel_t [NUM_OPS-1:0]             dest_sel_i,
    input  logic      [NUM_OPS-1:0][DATA_W-1:0] regs_i,
    input  logic      [NUM_OPS-1:0][SEG_W-1:0]  segs_i,
    input  logic      [DATA_W-1:0]              rdata1_i,
    input  logic      [DATA_W-1:0]              rdata2_i,
    input  logic      [ADDR_W-1:0]              addr1_i,
    input  logic      [ADDR_W-1:0]              addr2_i,
    input  logic      [DATA_W-1:0]              imm_i,
    input  logic      [31:0]                    eip_i,
    output logic      [NUM_OPS-1:0][DATA_W-1:0] op_val_o,
    output logic      [NUM_OPS-1:0][ADDR_W-1:0] dest_addr_o
);

    always_comb begin
        for (int i = 0; i < NUM_OPS; i++) begin
            case (dec_src_i[i].src)
                SRC_REG:  op_val_o[i] = regs_i[dec_src_i[i].idx];
                SRC_SEG:  op_val_o[i] = DATA_W'(segs_i[dec_src_i[i].idx]);
                SRC_MEM1: op_val_o[i] = mem_use_i.rd1 ? rdata1_i : '0;
                SRC_MEM2: op_val_o[i] = mem_use_i.rd2 ? rdata2_i : '0;
                SRC_IMM:  op_val_o[i] = imm_i;
                SRC_EIP:  op_val_o[i] = DATA_W'(eip_i);
                default:  op_val_o[i] = '0;
            endcase
        end
    end

    // register and segment destinations carry their index as the address
    always_comb begin
        for (int i = 0; i < NUM_OPS; i++) begin
            case (dest_sel_i[i].kind)
                DEST_REG:  dest_addr_o[i] = ADDR_W'(dest_sel_i[i].idx);
                DEST_SEG:  dest_addr_o[i] = ADDR_W'(dest_sel_i[i].idx);
                DEST_MEM1: dest_addr_o[i] = mem_use_i.wr1 ? addr1_i : '0;
                DEST_MEM2: dest_addr_o[i] = mem_use_i.wr2 ? addr2_i : '0;
                default:   dest_addr_o[i] = '0;
            endcase
        end
    end

endmodule

// File: hw/rep_addr_unit.sv
module rep_addr_unit import mem_stage_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  logic              is_rep_i,
    input  logic              df_i,
    input  op_size_e          size_i,
    input  logic [ADDR_W-1:0] mem_addr1_i,
    input  logic [ADDR_W-1:0] mem_addr2_i,
    input  logic [ADDR_W-1:0] count_i,
    input  logic              hold_i,
    output logic [ADDR_W-1:0] cur_addr1_o,
    output logic [ADDR_W-1:0] cur_addr2_o,
    output logic              item_valid_o,
    output logic              rep_stall_o
);

    rep_state_e        state_q;
    logic [ADDR_W-1:0] addr1_q;
    logic [ADDR_W-1:0] addr2_q;
    logic [ADDR_W-1:0] cnt_q;
    logic [ADDR_W-1:0] step_mag;
    logic [ADDR_W-1:0] step;
    logic [ADDR_W-1:0] cur_cnt;
    logic [ADDR_W-1:0] left_cnt;
    logic              running;
    logic              rep_zero;
    logic              rep_active;

    assign running = (state_q == REP_RUN);

    // df set walks the strings downwards
    assign step_mag = ADDR_W'(1) << size_i;
    assign step     = df_i ? (ADDR_W'(0) - step_mag) : step_mag;

    // first iteration comes straight from the inputs, later ones from the registers
    assign cur_addr1_o = running ? addr1_q : mem_addr1_i;
    assign cur_addr2_o = running ? addr2_q : mem_addr2_i;
    assign cur_cnt     = running ? cnt_q : count_i;
    assign left_cnt    = cur_cnt - ADDR_W'(1);

    assign rep_zero     = is_rep_i && (count_i == '0);
    assign rep_active   = running || (valid_i && is_rep_i && !rep_zero);
    assign item_valid_o = running || (valid_i && !rep_zero);
    assign rep_stall_o  = rep_active && (left_cnt != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= REP_IDLE;
            cnt_q   <= '0;
        end else if (rep_active && !hold_i) begin
            cnt_q   <= left_cnt;
            state_q <= (left_cnt != '0) ? REP_RUN : REP_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rep_active && !hold_i) begin
            addr1_q <= cur_addr1_o + step;
            addr2_q <= cur_addr2_o + step;
        end
    end

endmodule

// File: hw/stage_result_reg.sv
module stage_result_reg import mem_stage_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       item_valid_i,
    input  logic       fwd_stall_i,
    input  logic       rep_stall_i,
    input  stage_out_t next_i,
    output logic       valid_o,
    output stage_out_t out_o,
    output logic       stall_o,
    output logic       hold_o
);

    logic       valid_q;
    stage_out_t out_q;

    assign stall_o = rep_stall_i | fwd_stall_i;

    // only downstream back-pressure freezes the rep unit, its own stall must not
    assign hold_o = fwd_stall_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (!fwd_stall_i) begin
            valid_q <= item_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!fwd_stall_i) begin
            out_q <= next_i;
        end
    end

    assign valid_o = valid_q;
    assign out_o   = out_q;

endmodule

// File: mem_stage_top.f
hw/mem_stage_pkg.sv
hw/operand_decode.sv
hw/rep_addr_unit.sv
hw/data_mem.sv
hw/operand_mux.sv
hw/stage_result_reg.sv
hw/mem_stage_top.sv
test/tb_mem_stage.sv

// File: test/tb_mem_stage.sv
module tb_mem_stage import mem_stage_pkg::*; ();

    // cycle budget of the reset, operand, memory, rep, back-pressure and random tests
    localparam int RUN_CYCLES = 4 + 4 + 17 + 16 + 15 + 72;

    logic clk = 1'b0;
    logic rst_n_i = 1'b0;
    logic valid_i = 1'b0;
    logic df_i = 1'b0;
    logic is_rep_i = 1'b0;
    logic fwd_stall_i = 1'b0;
    logic wb_valid_i = 1'b0;
    op_sel_t    [NUM_OPS-1:0]             op_sel = '0;
    dest_sel_t  [NUM_OPS-1:0]             dest_sel = '0;
    op_size_e                             size = SZ_QWORD;
    logic       [ADDR_W-1:0]              addr1 = '0;
    logic       [ADDR_W-1:0]              addr2 = '0;
    logic       [ADDR_W-1:0]              count = '0;
    logic       [NUM_OPS-1:0][DATA_W-1:0] regs = '0;
    logic       [NUM_OPS-1:0][SEG_W-1:0]  segs = '0;
    logic       [DATA_W-1:0]              imm = '0;
    pipe_ctrl_t                           ctrl = '0;
    logic       [ADDR_W-1:0]              wb_addr = '0;
    logic       [DATA_W-1:0]              wb_data = '0;
    op_size_e                             wb_size = SZ_BYTE;
    logic                                 valid_o;
    logic                                 stall_o;
    stage_out_t                           out_o;

    // byte image of the data array
    logic [7:0] model_mem [MEM_WORDS*8];
    integer     seed = 41502;
    int         errors = 0;
    int         test_errs = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    string      cur_test;

    always #2 clk = ~clk;

    mem_stage_top DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .op_sel_i    (op_sel),
        .dest_sel_i  (dest_sel),
        .size_i      (size),
        .df_i        (df_i),
        .is_rep_i    (is_rep_i),
        .mem_addr1_i (addr1),
        .mem_addr2_i (addr2),
        .count_i     (count),
        .regs_i      (regs),
        .segs_i      (segs),
        .imm_i       (imm),
        .ctrl_i      (ctrl),
        .fwd_stall_i (fwd_stall_i),
        .wb_valid_i  (wb_valid_i),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .wb_size_i   (wb_size),
        .valid_o     (valid_o),
        .out_o       (out_o),
        .stall_o     (stall_o)
    );

    // bytes wrap inside their 8-byte word
    function automatic int byte_index(logic [ADDR_W-1:0] a, int b);
        return int'(a[10:3]) * 8 + (int'(a[2:0]) + b) % 8;
    endfunction

    function automatic logic [DATA_W-1:0] model_read(logic [ADDR_W-1:0] a, op_size_e sz);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int b = 0; b < (1 << sz); b++) begin
            v[b*8 +: 8] = model_mem[byte_index(a, b)];
        end
        return v;
    endfunction

    function automatic stage_out_t expect_out(logic [ADDR_W-1:0] a1, logic [ADDR_W-1:0] a2);
        stage_out_t e;
        e.size = size;
        e.ctrl = ctrl;
        for (int i = 0; i < NUM_OPS; i++) begin
            case (op_sel[i].src)
                SRC_REG:  e.op_val[i] = regs[op_sel[i].idx];
                SRC_SEG:  e.op_val[i] = {48'h0, segs[op_sel[i].idx]};
                SRC_MEM1: e.op_val[i] = model_read(a1, size);
                SRC_MEM2: e.op_val[i] = model_read(a2, size);
                SRC_IMM:  e.op_val[i] = imm;
                SRC_EIP:  e.op_val[i] = {32'h0, ctrl.eip};
                default:  e.op_val[i] = '0;
            endcase
            e.dest_kind[i] = dest_sel[i].kind;
            case (dest_sel[i].kind)
                DEST_REG, DEST_SEG: e.dest_addr[i] = {30'h0, dest_sel[i].idx};
                DEST_MEM1:          e.dest_addr[i] = a1;
                DEST_MEM2:          e.dest_addr[i] = a2;
                default:            e.dest_addr[i] = '0;
            endcase
        end
        return e;
    endfunction

    task automatic compare(string what, logic [511:0] exp, logic [511:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            errors += test_errs;
        end
        $display("%-14s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "failed", test_errs);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_sources();
        for (int i = 0; i < NUM_OPS; i++) begin
            regs[i] = {$random(seed), $random(seed)};
            segs[i] = 16'($random(seed));
        end
        imm  = {$random(seed), $random(seed)};
        ctrl = 47'({$random(seed), $random(seed)});
    endtask

    task automatic write_back(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d, op_size_e sz);
        wb_valid_i = 1'b1;
        wb_addr = a;
        wb_data = d;
        wb_size = sz;
        for (int b = 0; b < (1 << sz); b++) begin
            model_mem[byte_index(a, b)] = d[b*8 +: 8];
        end
        next_cycle();
        wb_valid_i = 1'b0;
    endtask

    // one non-REP instruction whose result appears one cycle later
    task automatic issue_plain();
        stage_out_t exp;
        valid_i = 1'b1;
        is_rep_i = 1'b0;
        exp = expect_out(addr1, addr2);
        @(negedge clk);
        compare("stall_o before accept", 0, stall_o);
        next_cycle();
        valid_i = 1'b0;
        compare("valid_o", 1, valid_o);
        compare("out_o", exp, out_o);
    endtask

    // stall_at names the item in front of which fwd_stall_i is raised for 2 cycles
    task automatic run_rep(logic dir, op_size_e sz, int cnt, int stall_at);
        stage_out_t exp;
        stage_out_t held;
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        int k;
        int guard;
        int held_cycles;
        logic accept;
        logic last;
        op_sel[0] = {SRC_MEM1, 2'd0};
        op_sel[1] = {SRC_MEM2, 2'd0};
        dest_sel[0] = {DEST_MEM1, 2'd0};
        dest_sel[1] = {DEST_MEM2, 2'd0};
        addr1 = 32'h0000_0046;
        addr2 = 32'h0000_0101;
        df_i = dir;
        size = sz;
        count = cnt;
        is_rep_i = 1'b1;
        valid_i = 1'b1;
        k = 0;
        guard = 0;
        held_cycles = 0;
        last = 1'b0;
        if (cnt == 0) begin
            @(negedge clk);
            compare("zero count stall_o", 0, stall_o);
            next_cycle();
            compare("zero count valid_o", 0, valid_o);
        end else begin
            while (!last && guard < 4 * cnt + 10) begin
                guard++;
                fwd_stall_i = (k == stall_at) && (held_cycles < 2);
                a1 = dir ? addr1 - k * (1 << sz) : addr1 + k * (1 << sz);
                a2 = dir ? addr2 - k * (1 << sz) : addr2 + k * (1 << sz);
                exp = expect_out(a1, a2);
                held = out_o;
                @(negedge clk);
                accept = !fwd_stall_i;
                last = accept && !stall_o;
                compare("stall_o", (cnt - k > 1) || fwd_stall_i, stall_o);
                next_cycle();
                if (accept) begin
                    compare("item valid_o", 1, valid_o);
                    compare("item out_o", exp, out_o);
                    k++;
                end else begin
                    held_cycles++;
                    compare("held out_o", held, out_o);
                end
            end
            if (!last) begin
                $display("%s: stall_o never dropped during the REP sequence", cur_test);
                test_errs++;
            end
            compare("item count", cnt, k);
        end
        valid_i = 1'b0;
        is_rep_i = 1'b0;
        fwd_stall_i = 1'b0;
        @(negedge clk);
        compare("stall_o after REP", 0, stall_o);
        next_cycle();
        compare("valid_o after REP", 0, valid_o);
    endtask

    task automatic reset_values();
        start_test("reset");
        compare("valid_o", 0, valid_o);
        @(negedge clk);
        compare("stall_o", 0, stall_o);
        next_cycle();
        finish_test();
    endtask

    task automatic operand_select();
        start_test("operands");
        fill_sources();
        op_sel[0] = {SRC_REG, 2'd2};
        op_sel[1] = {SRC_SEG, 2'd1};
        op_sel[2] = {SRC_IMM, 2'd0};
        op_sel[3] = {SRC_EIP, 2'd0};
        dest_sel[0] = {DEST_REG, 2'd3};
        dest_sel[1] = {DEST_SEG, 2'd1};
        dest_sel[2] = {DEST_NONE, 2'd2};
        dest_sel[3] = {DEST_REG, 2'd0};
        issue_plain();
        fill_sources();
        op_sel[0] = {SRC_SEG, 2'd3};
        op_sel[2] = {SRC_REG, 2'd0};
        dest_sel[2] = {DEST_SEG, 2'd2};
        issue_plain();
        finish_test();
    endtask

    task automatic memory_reads();
        logic [ADDR_W-1:0] rd_addr [6];
        rd_addr = '{32'h40, 32'h4D, 32'h48, 32'h81, 32'h107, 32'h43};
        start_test("memory");
        write_back(32'h40, 64'h8877_6655_4433_2211, SZ_QWORD);
        write_back(32'h4D, 64'h0000_0000_DDCC_BBAA, SZ_DWORD);
        write_back(32'h81, 64'h0000_0000_0000_F00D, SZ_WORD);
        write_back(32'h107, 64'h0000_0000_0000_005A, SZ_BYTE);
        write_back(32'h46, 64'h0123_4567_89AB_CDEF, SZ_QWORD);
        op_sel = '0;
        dest_sel = '0;
        op_sel[0] = {SRC_MEM1, 2'd0};
        op_sel[1] = {SRC_MEM2, 2'd0};
        dest_sel[0] = {DEST_MEM1, 2'd0};
        dest_sel[1] = {DEST_MEM2, 2'd0};
        for (int i = 0; i < 6; i++) begin
            addr1 = rd_addr[i];
            addr2 = rd_addr[5-i];
            size = op_size_e'(i % 4);
            issue_plain();
        end
        finish_test();
    endtask

    task automatic rep_stepping();
        start_test("rep");
        run_rep(1'b0, SZ_WORD, 5, -1);
        run_rep(1'b1, SZ_DWORD, 5, -1);
        run_rep(1'b0, SZ_BYTE, 0, -1);
        finish_test();
    endtask

    task automatic back_pressure();
        stage_out_t held;
        start_test("backpressure");
        fill_sources();
        op_sel[0] = {SRC_IMM, 2'd0};
        issue_plain();
        held = out_o;
        // the next instruction waits behind the stall
        imm = imm + 1;
        valid_i = 1'b1;
        fwd_stall_i = 1'b1;
        repeat (2) begin
            @(negedge clk);
            compare("stall_o under fwd stall", 1, stall_o);
            next_cycle();
            compare("held valid_o", 1, valid_o);
            compare("held out_o", held, out_o);
        end
        fwd_stall_i = 1'b0;
        issue_plain();
        next_cycle();
        compare("repeated item", 0, valid_o);
        run_rep(1'b1, SZ_QWORD, 4, 2);
        run_rep(1'b0, SZ_WORD, 3, 0);
        finish_test();
    endtask

    task automatic random_instructions();
        op_src_e pick [4];
        pick = '{SRC_REG, SRC_IMM, SRC_MEM1, SRC_MEM2};
        start_test("random");
        for (int n = 0; n < 24; n++) begin
            write_back({$random(seed)} % 64, {$random(seed), $random(seed)},
                       op_size_e'({$random(seed)} % 4));
            fill_sources();
            for (int i = 0; i < NUM_OPS; i++) begin
                op_sel[i] = {pick[{$random(seed)} % 4], 2'($random(seed))};
                dest_sel[i] = {dest_kind_e'({$random(seed)} % 5), 2'($random(seed))};
            end
            addr1 = {$random(seed)} % 64;
            addr2 = {$random(seed)} % 64;
            size = op_size_e'({$random(seed)} % 4);
            issue_plain();
        end
        finish_test();
    endtask

    initial begin
        #(RUN_CYCLES * 4 + 400);
        $display("watchdog expired before the tests completed");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        for (int i = 0; i < MEM_WORDS * 8; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        reset_values();
        operand_select();
        memory_reads();
        rep_stepping();
        back_pressure();
        random_instructions();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
